// File: hdl/pcPkg.sv
package pcPkg;

    // Address and data path width
    localparam int dataWidth = 16;

    typedef logic [dataWidth-1:0] addrT;
    typedef logic [3:0] minorOpT;

    // Minor opcode is scaled by eight to form the relative branch offset
    localparam int offsetShift = 3;

    // Fetch to execute distance, subtracted from pc for jump-and-link
    localparam addrT linkOffset = addrT'(5);

    // Values loaded while arstN is low
    localparam addrT resetPc = addrT'(0);
    localparam addrT resetRollback = addrT'(0);

    // Branch request from decode, valid as a level
    typedef struct packed {
        // Absolute jump to the immediate
        logic    branchEn;
        // Relative branch from the current pc
        logic    relBranchEn;
        minorOpT minorOp;
        // Condition operand, the branch goes only when it is zero
        addrT    operandA;
    } branchCtrlT;

    // Prediction state from the branch predictor
    typedef struct packed {
        logic speculating;
        logic predictTaken;
        // One cycle pulse at the start of a speculation
        logic beginSpec;
        addrT specDest;
    } specCtrlT;

    // Outcome of a branch, as seen on the cycle the pc advances
    typedef struct packed {
        logic resolving;
        logic taken;
        addrT target;
    } resolveT;

endpackage : pcPkg

// File: hdl/branchTarget.sv
`timescale 1ns/10ps

module branchTarget (
    input  pcPkg::branchCtrlT branch,
    input  pcPkg::addrT       imm,
    input  pcPkg::addrT       pc,
    output logic              taken,
    output pcPkg::addrT       target
);

    logic        operandZero;
    logic        anyBranch;
    pcPkg::addrT branchOffset;
    pcPkg::addrT relTarget;

    // Condition test on operand A
    assign operandZero = (branch.operandA == '0);

    assign anyBranch = branch.branchEn | branch.relBranchEn;

    // Offset is the minor opcode times eight, zero-extended to the full width
    assign branchOffset = pcPkg::addrT'(branch.minorOp) << pcPkg::offsetShift;

    // Relative destination counts from the current instruction address
    assign relTarget = pc + branchOffset;

    // Relative branch wins when decode raises both enables
    always_comb begin
        if (branch.relBranchEn) begin
            target = relTarget;
        end else begin
            target = imm;
        end
    end

    assign taken = operandZero & anyBranch;

endmodule : branchTarget

// File: hdl/speculationCheck.sv
`timescale 1ns/10ps

module speculationCheck (
    input  logic              clk,
    input  logic              arstN,
    input  logic              clkEn,
    input  pcPkg::specCtrlT   spec,
    input  pcPkg::addrT       pc,
    input  pcPkg::resolveT    resolve,
    output logic              rollback,
    output pcPkg::addrT       rollbackAddr,
    output logic              incorrectSpec
);

    pcPkg::addrT rollbackBuf;
    logic        checking;
    logic        wrongTaken;
    logic        wrongDest;
    logic        wrongNotTaken;
    logic        misSpec;

    // Rollback buffer holds the fall-through address of the speculated branch.
    // It is captured on the start pulse even while the pc is stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rollbackBuf <= pcPkg::resetRollback;
        end else if (clkEn && spec.beginSpec) begin
            rollbackBuf <= pc + pcPkg::addrT'(1);
        end
    end

    assign rollbackAddr = rollbackBuf;

    // A prediction is judged only on the cycle its branch resolves
    assign checking = spec.speculating & resolve.resolving;

    // Predicted taken, branch fell through
    assign wrongTaken = checking & spec.predictTaken & ~resolve.taken;

    // Predicted taken and taken, but to another address
    assign wrongDest = checking & spec.predictTaken & resolve.taken
        & (spec.specDest != resolve.target);

    // Predicted not taken, branch went
    assign wrongNotTaken = checking & ~spec.predictTaken & resolve.taken;

    assign misSpec = wrongTaken | wrongDest | wrongNotTaken;

    // Only a wrong taken guess needs the saved address, the other two cases
    // already follow the resolved target
    assign rollback = wrongTaken;

    // Pulse lines up with the cycle where pc shows the corrected address
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            incorrectSpec <= 1'b0;
        end else begin
            incorrectSpec <= misSpec;
        end
    end

    // Rollback may only come from a resolving branch under speculation
    rollbackNeedsSpec: assert property (
        @(posedge clk) disable iff (!arstN)
        rollback |-> (spec.speculating && resolve.resolving)
    ) else $error("speculationCheck: rollback outside a resolving speculation");

    // No stale mis-speculation pulse right after reset release
    quietAfterReset: assert property (
        @(posedge clk)
        $rose(arstN) |-> !incorrectSpec
    ) else $error("speculationCheck: incorrectSpec high after reset");

endmodule : speculationCheck

// File: hdl/programCounter.sv
`timescale 1ns/10ps

module programCounter (
    input  logic              clk,
    input  logic              arstN,
    input  logic              clkEn,
    input  logic              pcEnable,
    input  logic              stall,
    input  pcPkg::branchCtrlT branch,
    input  logic              taken,
    input  pcPkg::addrT       target,
    input  logic              rollback,
    input  pcPkg::addrT       rollbackAddr,
    output pcPkg::resolveT    resolve,
    output pcPkg::addrT       pc,
    output pcPkg::addrT       linkData
);

    logic        advance;
    pcPkg::addrT nextPc;

    // The register moves only when enabled and not held by back-pressure
    assign advance = clkEn & ~stall & pcEnable;

    // Speculation block sees a branch only on a cycle that really advances
    always_comb begin
        resolve.resolving = advance & (branch.branchEn | branch.relBranchEn);
        resolve.taken = taken;
        resolve.target = target;
    end

    // Rollback first, then a taken branch, then the next word
    always_comb begin
        if (rollback) begin
            nextPc = rollbackAddr;
        end else if (taken) begin
            nextPc = target;
        end else begin
            nextPc = pc + pcPkg::addrT'(1);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= pcPkg::resetPc;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

    // Link value points back to the instruction now in execute
    assign linkData = pc - pcPkg::linkOffset;

    // A held cycle must leave the address alone, whatever the branch inputs do
    holdWhenIdle: assert property (
        @(posedge clk) disable iff (!arstN)
        !advance |=> $stable(pc)
    ) else $error("programCounter: pc moved without advance");

endmodule : programCounter

// File: hdl/pcUnit.sv
`timescale 1ns/10ps

module pcUnit (
    input  logic              clk,
    input  logic              arstN,
    input  logic              clkEn,
    input  logic              pcEnable,
    input  logic              stall,
    input  pcPkg::branchCtrlT branch,
    input  pcPkg::specCtrlT   spec,
    input  pcPkg::addrT       imm,
    output pcPkg::addrT       pc,
    output pcPkg::addrT       linkData,
    output logic              incorrectSpec
);

    logic           taken;
    pcPkg::addrT    target;
    logic           rollback;
    pcPkg::addrT    rollbackAddr;
    pcPkg::resolveT resolve;

    // Destination of the branch currently presented by decode
    branchTarget branchTarget0 (
        .branch (branch),
        .imm    (imm),
        .pc     (pc),
        .taken  (taken),
        .target (target)
    );

    // Prediction check and rollback buffer
    speculationCheck speculationCheck0 (
        .clk           (clk),
        .arstN         (arstN),
        .clkEn         (clkEn),
        .spec          (spec),
        .pc            (pc),
        .resolve       (resolve),
        .rollback      (rollback),
        .rollbackAddr  (rollbackAddr),
        .incorrectSpec (incorrectSpec)
    );

    programCounter programCounter0 (
        .clk          (clk),
        .arstN        (arstN),
        .clkEn        (clkEn),
        .pcEnable     (pcEnable),
        .stall        (stall),
        .branch       (branch),
        .taken        (taken),
        .target       (target),
        .rollback     (rollback),
        .rollbackAddr (rollbackAddr),
        .resolve      (resolve),
        .pc           (pc),
        .linkData     (linkData)
    );

endmodule : pcUnit

// File: tb/pcUnitTb.sv
`timescale 1ns/10ps

module pcUnitTb;

    localparam int resetCycles = 10;
    localparam int edgeLimit = 4;
    localparam int watchdogCycles = 2000;
    localparam string dataPath = "tb/pcTestdata.txt";

    logic              clk;
    logic              arstN;
    logic              clkEn;
    logic              pcEnable;
    logic              stall;
    pcPkg::branchCtrlT branch;
    pcPkg::specCtrlT   spec;
    pcPkg::addrT       imm;
    pcPkg::addrT       pc;
    pcPkg::addrT       linkData;
    logic              incorrectSpec;

    int valueErrors;
    int otherErrors;
    int rowsRun;
    bit runDone = 1'b0;

    pcUnit dut0 (
        .clk           (clk),
        .arstN         (arstN),
        .clkEn         (clkEn),
        .pcEnable      (pcEnable),
        .stall         (stall),
        .branch        (branch),
        .spec          (spec),
        .imm           (imm),
        .pc            (pc),
        .linkData      (linkData),
        .incorrectSpec (incorrectSpec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Returns on the next falling clock edge, or gives up after a few edges
    task automatic waitFallingEdge(output bit seen);
        int edges;
        seen = 1'b0;
        edges = 0;
        while (!seen && edges < edgeLimit) begin
            @(clk);
            edges++;
            if (clk == 1'b0) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic driveIdle();
        clkEn = 1'b0;
        pcEnable = 1'b0;
        stall = 1'b0;
        branch = '0;
        spec = '0;
        imm = '0;
    endtask

    // Comment lines start with a hash
    function automatic bit isCommentOrBlank(input string text);
        byte c;
        for (int i = 0; i < text.len(); i++) begin
            c = text[i];
            if (c == "#") begin
                return 1'b1;
            end
            if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // A dash in the data file marks a word that has no effect on that row
    function automatic bit wordOrIdle(input string token, output pcPkg::addrT value);
        int unsigned randomWord;
        int          count;
        pcPkg::addrT parsed;
        value = '0;
        if (token == "-") begin
            randomWord = $urandom();
            value = randomWord[pcPkg::dataWidth-1:0];
            return 1'b1;
        end
        count = $sscanf(token, "%h", parsed);
        value = parsed;
        return (count == 1);
    endfunction

    task automatic checkOutputs(input string testName, input pcPkg::addrT expPc,
                                input pcPkg::addrT expLink, input logic expInc);
        assert (pc === expPc)
            else begin
                $display("ERROR %s: pc expected %h, actual %h", testName, expPc, pc);
                valueErrors++;
            end
        assert (linkData === expLink)
            else begin
                $display("ERROR %s: linkData expected %h, actual %h",
                         testName, expLink, linkData);
                valueErrors++;
            end
        assert (incorrectSpec === expInc)
            else begin
                $display("ERROR %s: incorrectSpec expected %b, actual %b",
                         testName, expInc, incorrectSpec);
                valueErrors++;
            end
    endtask

    initial begin : stimulus
        int          fd;
        int          lineNo;
        int          fieldCount;
        bit          seen;
        bit          stopRun;
        bit          immOk;
        bit          destOk;
        string       line;
        string       testName;
        string       immTok;
        string       destTok;
        logic        fClkEn;
        logic        fPcEnable;
        logic        fStall;
        logic        fBranchEn;
        logic        fRelEn;
        logic [3:0]  fMinorOp;
        pcPkg::addrT fOperandA;
        logic        fSpeculating;
        logic        fPredict;
        logic        fBegin;
        pcPkg::addrT immVal;
        pcPkg::addrT destVal;
        pcPkg::addrT expPc;
        pcPkg::addrT expLink;
        logic        expInc;

        valueErrors = 0;
        otherErrors = 0;
        rowsRun = 0;
        stopRun = 1'b0;
        void'($urandom(32'h6b9b));
        arstN = 1'b0;
        driveIdle();

        for (int i = 0; i < resetCycles && !stopRun; i++) begin
            waitFallingEdge(seen);
            if (!seen) begin
                $display("Clock stopped toggling during reset");
                otherErrors++;
                stopRun = 1'b1;
            end
        end
        arstN = 1'b1;

        fd = $fopen(dataPath, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", dataPath);
            otherErrors++;
        end else begin
            lineNo = 0;
            while (!stopRun && $fgets(line, fd) != 0) begin
                lineNo++;
                if (!isCommentOrBlank(line)) begin
                    fieldCount = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %s %h %h %h %s %h %h %h",
                        testName, fClkEn, fPcEnable, fStall, fBranchEn, fRelEn,
                        fMinorOp, fOperandA, immTok, fSpeculating, fPredict, fBegin,
                        destTok, expPc, expLink, expInc);
                    immOk = 1'b0;
                    destOk = 1'b0;
                    if (fieldCount == 16) begin
                        immOk = wordOrIdle(immTok, immVal);
                        destOk = wordOrIdle(destTok, destVal);
                    end
                    if (!immOk || !destOk) begin
                        $display("Line %0d of the test data file is malformed and was skipped",
                                 lineNo);
                        otherErrors++;
                    end else begin
                        // Row inputs change on the falling edge, results follow one rise
                        clkEn = fClkEn;
                        pcEnable = fPcEnable;
                        stall = fStall;
                        branch.branchEn = fBranchEn;
                        branch.relBranchEn = fRelEn;
                        branch.minorOp = fMinorOp;
                        branch.operandA = fOperandA;
                        imm = immVal;
                        spec.speculating = fSpeculating;
                        spec.predictTaken = fPredict;
                        spec.beginSpec = fBegin;
                        spec.specDest = destVal;
                        waitFallingEdge(seen);
                        if (!seen) begin
                            $display("Clock stopped toggling during row %s", testName);
                            otherErrors++;
                            stopRun = 1'b1;
                        end else begin
                            checkOutputs(testName, expPc, expLink, expInc);
                            rowsRun++;
                        end
                    end
                end
            end
            $fclose(fd);
            if (rowsRun == 0) begin
                $display("The test data file held no usable rows");
                otherErrors++;
            end
        end

        driveIdle();
        runDone = 1'b1;
        $display("Rows checked: %0d, value errors: %0d, other errors: %0d",
                 rowsRun, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Time based guard, so a stuck clock still ends the run
    initial begin : watchdog
        int waited;
        waited = 0;
        while (!runDone && waited < watchdogCycles) begin
            #20;
            waited++;
        end
        if (!runDone) begin
            $display("Simulation did not finish within %0d clock periods", watchdogCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule : pcUnitTb

// File: tb/pcTestdata.txt
# name clkEn pcEnable stall branchEn relBranchEn minorOp operandA imm speculating predictTaken
# beginSpec specDest expPc expLink expInc, all hex, a dash is a word with no effect
# Sequential advance from reset
seqAdvance0       1 1 0 0 0 0 0000 -    0 0 0 -    0001 fffc 0
seqAdvance1       1 1 0 0 0 0 0000 -    0 0 0 -    0002 fffd 0
seqAdvance2       1 1 0 0 0 0 0000 -    0 0 0 -    0003 fffe 0
seqAdvance3       1 1 0 0 0 0 0000 -    0 0 0 -    0004 ffff 0
seqAdvance4       1 1 0 0 0 0 0000 -    0 0 0 -    0005 0000 0
seqAdvance5       1 1 0 0 0 0 0000 -    0 0 0 -    0006 0001 0
# Held cycles, a branch on them has no effect
clkEnLow          0 1 0 0 0 0 0000 -    0 0 0 -    0006 0001 0
stallJump         1 1 1 1 0 0 0000 0100 0 0 0 -    0006 0001 0
pcEnLowRel        1 0 0 0 1 2 0000 -    0 0 0 -    0006 0001 0
clkEnLowJump      0 1 0 1 0 0 0000 0200 0 0 0 -    0006 0001 0
resumeAdvance     1 1 0 0 0 0 0000 -    0 0 0 -    0007 0002 0
# Absolute jumps, relative branches and fall-through
absJump           1 1 0 1 0 0 0000 0040 0 0 0 -    0040 003b 0
afterAbsJump      1 1 0 0 0 0 0000 -    0 0 0 -    0041 003c 0
relBranch         1 1 0 0 1 3 0000 -    0 0 0 -    0059 0054 0
absNonZero        1 1 0 1 0 0 0005 0300 0 0 0 -    005a 0055 0
relNonZero        1 1 0 0 1 f 1234 -    0 0 0 -    005b 0056 0
bothEnables       1 1 0 1 1 4 0000 0500 0 0 0 -    007b 0076 0
relMaxOffset      1 1 0 0 1 f 0000 -    0 0 0 -    00f3 00ee 0
jumpHigh          1 1 0 1 0 0 0000 fffe 0 0 0 -    fffe fff9 0
wrapHigh          1 1 0 0 0 0 0000 -    0 0 0 -    ffff fffa 0
wrapZero          1 1 0 0 0 0 0000 -    0 0 0 -    0000 fffb 0
jumpBack          1 1 0 1 0 0 0000 0100 0 0 0 -    0100 00fb 0
# Correct predictions
specBeginTaken    1 1 0 0 0 0 0000 -    1 1 1 0180 0101 00fc 0
specHitTaken      1 1 0 1 0 0 0000 0180 1 1 0 0180 0180 017b 0
afterHitTaken     1 1 0 0 0 0 0000 -    0 0 0 -    0181 017c 0
specBeginNt       1 1 0 0 0 0 0000 -    1 0 1 -    0182 017d 0
specHitNotTaken   1 1 0 1 0 0 0007 -    1 0 0 -    0183 017e 0
afterHitNt        1 1 0 0 0 0 0000 -    0 0 0 -    0184 017f 0
# Wrong taken prediction loads the rollback address
specBeginWt       1 1 0 0 0 0 0000 -    1 1 1 0400 0185 0180 0
specHoldWt        1 1 0 0 0 0 0000 -    1 1 0 0400 0186 0181 0
specWrongTaken    1 1 0 0 1 2 0001 -    1 1 0 0400 0185 0180 1
afterWrongTaken   1 1 0 0 0 0 0000 -    0 0 0 -    0186 0181 0
specBeginStall    1 1 1 0 0 0 0000 -    1 1 1 0600 0186 0181 0
specHoldStall     1 1 0 0 0 0 0000 -    1 1 0 0600 0187 0182 0
stalledResolve    1 1 1 1 0 0 0009 -    1 1 0 0600 0187 0182 0
specWrongTaken2   1 1 0 1 0 0 0009 -    1 1 0 0600 0187 0182 1
stallAfterMiss    1 1 1 0 0 0 0000 -    0 0 0 -    0187 0182 0
# Wrong destination and wrong not-taken follow the actual target
specBeginWd       1 1 0 0 0 0 0000 -    1 1 1 0700 0188 0183 0
specWrongDest     1 1 0 1 0 0 0000 0800 1 1 0 0700 0800 07fb 1
afterWrongDest    1 1 0 0 0 0 0000 -    0 0 0 -    0801 07fc 0
specBeginWnt      1 1 0 0 0 0 0000 -    1 0 1 -    0802 07fd 0
specWrongNotTaken 1 1 0 0 1 5 0000 -    1 0 0 -    082a 0825 1
afterWrongNt      1 1 0 0 0 0 0000 -    0 0 0 -    082b 0826 0

// File: tb.f
hdl/pcPkg.sv
hdl/branchTarget.sv
hdl/speculationCheck.sv
hdl/programCounter.sv
hdl/pcUnit.sv
tb/pcUnitTb.sv

// File: run.sh
#!/bin/sh
# Builds the pcUnit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f tb.f --top-module pcUnitTb -o pcUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/pcUnitSim > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$logFile"; then
    echo "Simulation reported failure, see $logFile"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
